// ==== include/keyboardKeys.svh ====
`ifndef KEYBOARDKEYS_SVH
`define KEYBOARDKEYS_SVH

// panel keys inside the 40-bit key-state vector from the trainer keyboard
localparam int keyVectorWidth = 40;

localparam int keyIram    = 32; // show instruction RAM
localparam int keyDram    = 33; // show data RAM
localparam int keyCin     = 34; // console input
localparam int keyCout    = 35; // console output

// hard reset of the panel, starts a new clear sweep
localparam int keyHardRst = 39;

`endif

// ==== source/panelPkg.sv ====
package panelPkg;

    `include "keyboardKeys.svh"

    // views of the front-panel display, encoding shared with the display side
    typedef enum logic [2:0] {
        viewRestart = 3'd0,
        viewIram    = 3'd1,
        viewDram    = 3'd2,
        viewCin     = 3'd3,
        viewCout    = 3'd4
    } panelView_e;

    // processor states as seen by the panel
    // only execute matters here, the rest just pass through the delay line
    typedef enum logic [2:0] {
        dpcIdle      = 3'd0,
        dpcFetch     = 3'd1,
        dpcExecute   = 3'd2,
        dpcMemory    = 3'd3,
        dpcWriteBack = 3'd4,
        dpcHalt      = 3'd5,
        dpcWait      = 3'd6,
        dpcFault     = 3'd7
    } dpcState_e;

    // one display cell write, with flags telling the display what to latch
    typedef struct packed {
        logic [7:0] address;
        logic [7:0] symbol;
        logic       addrChanged;
        logic       dataChanged;
    } cell_t;

    localparam logic [7:0] spaceCode = 8'h20; // blank cell
    localparam logic [7:0] noKeyCode = 8'h00; // symbol value when nothing is typed

    // the display takes a 7-bit character code, bit 7 stays zero
    localparam int displayCodeBits = 7;

endpackage

// ==== source/viewSelector.sv ====
module viewSelector import panelPkg::*; #(
    parameter int columns = 16,
    parameter int rows = 10
) (
    input  logic                      Clock_1ms,
    input  logic                      Rst_n,
    input  logic [keyVectorWidth-1:0] keysCurrentState,
    output panelView_e                view,
    output cell_t                     sweepCell
);

    localparam int cellCount = columns * rows;
    localparam logic [7:0] lastCell = 8'(cellCount - 1);

    panelView_e nextView;
    logic [7:0] sweepCount;
    logic       sweepDone;

    assign sweepDone = (sweepCount == lastCell);

    // keys are level sensitive, first match in priority order wins
    always_comb begin
        nextView = view;
        if (view == viewRestart) begin
            // keys ignored until every cell has been blanked
            if (sweepDone) begin
                nextView = viewIram;
            end
        end else if (keysCurrentState[keyIram]) begin
            nextView = viewIram;
        end else if (keysCurrentState[keyDram]) begin
            nextView = viewDram;
        end else if (keysCurrentState[keyCin]) begin
            nextView = viewCin;
        end else if (keysCurrentState[keyCout]) begin
            nextView = viewCout;
        end else if (keysCurrentState[keyHardRst]) begin
            nextView = viewRestart;
        end
    end

    always_ff @(posedge Clock_1ms or negedge Rst_n) begin
        if (!Rst_n) begin
            view <= viewRestart;
        end else begin
            view <= nextView;
        end
    end

    // clear-sweep counter, one cell per tick
    always_ff @(posedge Clock_1ms or negedge Rst_n) begin
        if (!Rst_n) begin
            sweepCount <= '0;
        end else if (view == viewRestart) begin
            sweepCount <= sweepDone ? 8'd0 : sweepCount + 8'd1;
        end else if (nextView == viewRestart) begin
            sweepCount <= '0; // hard-reset key, start from the first cell
        end
    end

    // blank every cell and make the display latch both address and data
    assign sweepCell = '{
        address:     sweepCount,
        symbol:      spaceCode,
        addrChanged: 1'b1,
        dataChanged: 1'b1
    };

endmodule

// ==== source/keyEntry.sv ====
module keyEntry import panelPkg::*; (
    input  logic       Clock_1ms,
    input  logic       Rst_n,
    input  logic [7:0] ipAddress,
    input  logic [7:0] symbol,
    output cell_t      entryCell
);

    cell_t      nextCell;
    logic [7:0] typedSymbol;

    // no key pressed shows as a blank
    assign typedSymbol = (symbol == noKeyCode) ? spaceCode : symbol;

    always_comb begin
        nextCell.address = ipAddress;
        nextCell.symbol  = typedSymbol;
        // compare against what was registered one tick ago
        nextCell.addrChanged = (ipAddress != entryCell.address);
        nextCell.dataChanged = (typedSymbol != entryCell.symbol);
    end

    always_ff @(posedge Clock_1ms or negedge Rst_n) begin
        if (!Rst_n) begin
            entryCell <= '0;
        end else begin
            entryCell <= nextCell;
        end
    end

endmodule

// ==== source/displayWriter.sv ====
module displayWriter import panelPkg::*; (
    input  logic       Clock_1ms,
    input  logic       Rst_n,
    input  panelView_e view,
    input  cell_t      sweepCell,
    input  cell_t      entryCell,
    input  dpcState_e  dpcState,
    output logic [7:0] address,
    output logic [7:0] data,
    output logic       addrAcq,
    output logic       dataAcq,
    output logic       marker,
    output panelView_e currentView
);

    cell_t     selCell;
    dpcState_e dpcDelayed; // first stage, lines dpcState up with view

    // the sweep owns the display while restarting
    assign selCell = (view == viewRestart) ? sweepCell : entryCell;

    always_ff @(posedge Clock_1ms or negedge Rst_n) begin
        if (!Rst_n) begin
            address <= '0;
            data    <= '0;
        end else begin
            address <= selCell.address;
            // display code is active low on the 7 character bits
            data    <= {1'b0, ~selCell.symbol[displayCodeBits-1:0]};
        end
    end

    // acquisition strobes, low for one tick per changed field
    always_ff @(posedge Clock_1ms or negedge Rst_n) begin
        if (!Rst_n) begin
            addrAcq <= 1'b1;
            dataAcq <= 1'b1;
        end else begin
            addrAcq <= ~selCell.addrChanged;
            dataAcq <= ~selCell.dataChanged;
        end
    end

    always_ff @(posedge Clock_1ms or negedge Rst_n) begin
        if (!Rst_n) begin
            currentView <= viewRestart;
            dpcDelayed  <= dpcIdle;
            marker      <= 1'b0;
        end else begin
            currentView <= view;
            dpcDelayed  <= dpcState;
            // processor executing while the instruction RAM is on screen
            marker      <= (view == viewIram) && (dpcDelayed == dpcExecute);
        end
    end

endmodule

// ==== source/displayPanel.sv ====
module displayPanel import panelPkg::*; #(
    parameter int columns = 16,
    parameter int rows = 10
) (
    input  logic                      Clock_1ms,
    input  logic                      Rst_n,
    input  logic [keyVectorWidth-1:0] keysCurrentState,
    input  logic [7:0]                ipAddress,
    input  logic [7:0]                symbol,    // zero when no key is typed
    input  dpcState_e                 dpcState,
    output logic [7:0]                address,
    output logic [7:0]                data,
    output logic                      addrAcq,
    output logic                      dataAcq,
    output logic                      marker,
    output panelView_e                currentView
);

    panelView_e view;
    cell_t      sweepCell;
    cell_t      entryCell;

    // view state machine and clear sweep
    viewSelector #(
        .columns(columns),
        .rows   (rows)
    ) i_viewSelector (
        .Clock_1ms       (Clock_1ms),
        .Rst_n           (Rst_n),
        .keysCurrentState(keysCurrentState),
        .view            (view),
        .sweepCell       (sweepCell)
    );

    keyEntry i_keyEntry (
        .Clock_1ms(Clock_1ms),
        .Rst_n    (Rst_n),
        .ipAddress(ipAddress),
        .symbol   (symbol),
        .entryCell(entryCell)
    );

    // merges both cell sources onto the display bus
    displayWriter i_displayWriter (
        .Clock_1ms  (Clock_1ms),
        .Rst_n      (Rst_n),
        .view       (view),
        .sweepCell  (sweepCell),
        .entryCell  (entryCell),
        .dpcState   (dpcState),
        .address    (address),
        .data       (data),
        .addrAcq    (addrAcq),
        .dataAcq    (dataAcq),
        .marker     (marker),
        .currentView(currentView)
    );

endmodule

// ==== tests/displayPanel_props.sv ====
module displayPanelProps import panelPkg::*; (
    input logic       Clock_1ms,
    input logic       Rst_n,
    input logic [7:0] data,
    input logic       addrAcq,
    input logic       dataAcq,
    input logic       marker,
    input panelView_e currentView
);

    int failCount = 0;

    // character code is 7 bits wide, the top bit never carries anything
    property dataTopBitClear;
        @(posedge Clock_1ms) disable iff (!Rst_n)
            data[7] == 1'b0;
    endproperty

    property markerOnlyInIram;
        @(posedge Clock_1ms) disable iff (!Rst_n)
            marker |-> (currentView == viewIram);
    endproperty

    // the sweep writes a new cell every tick, so both strobes stay low
    property sweepStrobesLow;
        @(posedge Clock_1ms) disable iff (!Rst_n)
            (currentView == viewRestart && $past(Rst_n)) |-> (!addrAcq && !dataAcq);
    endproperty

    assert property (dataTopBitClear) else begin
        failCount = failCount + 1;
        $error("data bit 7 is set");
    end

    assert property (markerOnlyInIram) else begin
        failCount = failCount + 1;
        $error("marker high outside the instruction RAM view");
    end

    assert property (sweepStrobesLow) else begin
        failCount = failCount + 1;
        $error("acquisition strobe inactive during the clear sweep");
    end

endmodule

bind displayPanel displayPanelProps i_props (
    .Clock_1ms  (Clock_1ms),
    .Rst_n      (Rst_n),
    .data       (data),
    .addrAcq    (addrAcq),
    .dataAcq    (dataAcq),
    .marker     (marker),
    .currentView(currentView)
);

// ==== tests/displayPanelTb.sv ====
module displayPanelTb import panelPkg::*; ();

    localparam int columns = 16;
    localparam int rows = 10;
    localparam int cellCount = columns * rows;

    localparam int resetCycles = 8;
    localparam int sweepPhase = cellCount + 8;
    localparam int keyPhase = 200;
    localparam int entryPhase = 300;
    localparam int markerPhase = 200;
    localparam int hardRstPhase = cellCount + 16;
    localparam int totalCycles = resetCycles + sweepPhase + keyPhase + entryPhase
                               + markerPhase + hardRstPhase;
    localparam int timeoutCycles = totalCycles + 50;

    logic                      Clock_1ms = 1'b0;
    logic                      Rst_n;
    logic [keyVectorWidth-1:0] keysCurrentState;
    logic [7:0]                ipAddress;
    logic [7:0]                symbol;
    dpcState_e                 dpcState;
    logic [7:0]                address;
    logic [7:0]                data;
    logic                      addrAcq;
    logic                      dataAcq;
    logic                      marker;
    panelView_e                currentView;

    // reference model state
    panelView_e mView;
    int         mCount;
    logic [7:0] mEntryAddr;
    logic [7:0] mEntrySym;
    logic       mEntryAddrCh;
    logic       mEntryDataCh;
    dpcState_e  mDpcLast;

    // expected outputs after the latest rising edge
    logic [7:0] expAddress;
    logic [7:0] expData;
    logic       expAddrAcq;
    logic       expDataAcq;
    logic       expMarker;
    panelView_e expView;

    logic [31:0] rngState = 32'h4d9a1647;
    int          cycleCount;

    displayPanel #(
        .columns(columns),
        .rows   (rows)
    ) i_dut (
        .Clock_1ms       (Clock_1ms),
        .Rst_n           (Rst_n),
        .keysCurrentState(keysCurrentState),
        .ipAddress       (ipAddress),
        .symbol          (symbol),
        .dpcState        (dpcState),
        .address         (address),
        .data            (data),
        .addrAcq         (addrAcq),
        .dataAcq         (dataAcq),
        .marker          (marker),
        .currentView     (currentView)
    );

    always #5 Clock_1ms = ~Clock_1ms;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    // active-low 7-bit character code as the display expects it
    function automatic logic [7:0] displayCode(input logic [7:0] sym);
        return {1'b0, ~sym[6:0]};
    endfunction

    function automatic logic [keyVectorWidth-1:0] singleKey(input int index);
        logic [keyVectorWidth-1:0] keys;
        keys = '0;
        keys[index] = 1'b1;
        return keys;
    endfunction

    // Iram beats Dram beats Cin beats Cout beats the hard reset key
    function automatic panelView_e priorityView(input logic [keyVectorWidth-1:0] keys,
                                                input panelView_e current);
        if (keys[keyIram]) begin
            return viewIram;
        end else if (keys[keyDram]) begin
            return viewDram;
        end else if (keys[keyCin]) begin
            return viewCin;
        end else if (keys[keyCout]) begin
            return viewCout;
        end else if (keys[keyHardRst]) begin
            return viewRestart;
        end
        return current; // nothing pressed
    endfunction

    function automatic logic [keyVectorWidth-1:0] randomKeys(input logic allowHardRst);
        logic [31:0]               noise;
        logic [31:0]               pick;
        logic [keyVectorWidth-1:0] keys;
        noise = nextRandom();
        pick = nextRandom();
        keys = {8'h00, noise}; // other keyboard keys in the low bits
        keys[38:36] = pick[14:12];
        keys[keyIram] = (pick[1:0] == 2'd0);
        keys[keyDram] = (pick[3:2] == 2'd0);
        keys[keyCin] = (pick[5:4] == 2'd0);
        keys[keyCout] = (pick[7:6] == 2'd0);
        keys[keyHardRst] = allowHardRst && (pick[11:8] == 4'd0);
        return keys;
    endfunction

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("Fail at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("Test failed");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic resetModel();
        mView = viewRestart;
        mCount = 0;
        mEntryAddr = 8'h00;
        mEntrySym = 8'h00;
        mEntryAddrCh = 1'b0;
        mEntryDataCh = 1'b0;
        mDpcLast = dpcIdle;
        expAddress = 8'h00;
        expData = 8'h00;
        expAddrAcq = 1'b1;
        expDataAcq = 1'b1;
        expMarker = 1'b0;
        expView = viewRestart;
    endtask

    // one rising edge of the whole subsystem
    task automatic updateModel();
        logic [7:0] selAddress;
        logic [7:0] selSymbol;
        logic       selAddrCh;
        logic       selDataCh;
        logic [7:0] typedSymbol;
        panelView_e newView;
        if (!Rst_n) begin
            resetModel();
        end else begin
            if (mView == viewRestart) begin
                selAddress = 8'(mCount);
                selSymbol = spaceCode;
                selAddrCh = 1'b1;
                selDataCh = 1'b1;
            end else begin
                selAddress = mEntryAddr;
                selSymbol = mEntrySym;
                selAddrCh = mEntryAddrCh;
                selDataCh = mEntryDataCh;
            end
            expAddress = selAddress;
            expData = displayCode(selSymbol);
            expAddrAcq = !selAddrCh;
            expDataAcq = !selDataCh;
            expMarker = (mView == viewIram) && (mDpcLast == dpcExecute);
            expView = mView;
            mDpcLast = dpcState;

            typedSymbol = (symbol == 8'h00) ? spaceCode : symbol;
            mEntryAddrCh = (ipAddress != mEntryAddr);
            mEntryDataCh = (typedSymbol != mEntrySym);
            mEntryAddr = ipAddress;
            mEntrySym = typedSymbol;

            if (mView == viewRestart) begin
                if (mCount == cellCount - 1) begin
                    newView = viewIram;
                    mCount = 0;
                end else begin
                    newView = viewRestart;
                    mCount = mCount + 1;
                end
            end else begin
                newView = priorityView(keysCurrentState, mView);
                if (newView == viewRestart) begin
                    mCount = 0; // hard reset key
                end
            end
            mView = newView;
        end
    endtask

    task automatic compareOutputs();
        checkValue(32'(address), 32'(expAddress), "address");
        checkValue(32'(data), 32'(expData), "data");
        checkValue(32'(addrAcq), 32'(expAddrAcq), "addrAcq");
        checkValue(32'(dataAcq), 32'(expDataAcq), "dataAcq");
        checkValue(32'(marker), 32'(expMarker), "marker");
        checkValue(32'(currentView), 32'(expView), "currentView");
        checkValue(32'(i_dut.i_props.failCount), 32'(0), "assertion failure count");
    endtask

    // inputs are stable across the rising edge, outputs are read at the falling one
    task automatic stepCycle();
        @(posedge Clock_1ms);
        updateModel();
        @(negedge Clock_1ms);
        compareOutputs();
    endtask

    task automatic driveRandomEntry();
        logic [31:0] r;
        r = nextRandom();
        if (r[0]) begin
            ipAddress = r[15:8]; // else the address repeats
        end
        if (r[3:2] == 2'd0) begin
            symbol = 8'h00;
        end else if (r[3:2] != 2'd1) begin
            symbol = r[23:16];
        end
        dpcState = r[4] ? dpcExecute : dpcState_e'(r[7:5]);
    endtask

    initial begin
        cycleCount = 0;
        while (cycleCount < timeoutCycles) begin
            @(posedge Clock_1ms);
            cycleCount = cycleCount + 1;
        end
        $display("Timeout: the test did not finish within %0d cycles", timeoutCycles);
        $display("Test failed");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] r;
        Rst_n = 1'b0;
        keysCurrentState = '0;
        ipAddress = 8'h00;
        symbol = 8'h00;
        dpcState = dpcIdle;
        resetModel();
        repeat (resetCycles) stepCycle();
        Rst_n = 1'b1;

        // clear sweep, random keys must not disturb it
        for (int i = 1; i <= sweepPhase; i++) begin
            if (i <= cellCount - 4) begin
                keysCurrentState = randomKeys(1'b1);
            end else begin
                keysCurrentState = '0;
            end
            driveRandomEntry();
            stepCycle();
            if (i <= cellCount) begin
                checkValue(32'(address), 32'(i - 1), "sweep address");
                checkValue(32'(data), 32'(displayCode(spaceCode)), "sweep data");
                checkValue(32'(addrAcq), 32'(0), "sweep addrAcq");
                checkValue(32'(dataAcq), 32'(0), "sweep dataAcq");
                checkValue(32'(currentView), 32'(viewRestart), "sweep view");
            end
        end
        checkValue(32'(currentView), 32'(viewIram), "view after sweep");

        for (int i = 0; i < keyPhase; i++) begin
            keysCurrentState = randomKeys(1'b0);
            driveRandomEntry();
            stepCycle();
        end

        keysCurrentState = '0; // view holds during entry writing
        for (int i = 0; i < entryPhase; i++) begin
            driveRandomEntry();
            stepCycle();
        end

        for (int i = 0; i < markerPhase; i++) begin
            r = nextRandom();
            if (r[1:0] != 2'd0) begin
                keysCurrentState = singleKey(keyIram);
            end else begin
                keysCurrentState = randomKeys(1'b0);
            end
            driveRandomEntry();
            stepCycle();
        end

        // hard reset loses against a higher key
        keysCurrentState = singleKey(keyHardRst) | singleKey(keyCout);
        repeat (6) begin
            driveRandomEntry();
            stepCycle();
        end
        checkValue(32'(currentView), 32'(viewCout), "view with hard reset and Cout");

        keysCurrentState = singleKey(keyHardRst);
        driveRandomEntry();
        stepCycle();
        keysCurrentState = randomKeys(1'b1);
        driveRandomEntry();
        stepCycle();
        checkValue(32'(currentView), 32'(viewRestart), "view after hard reset");
        checkValue(32'(address), 32'(0), "first sweep address after hard reset");
        for (int i = 0; i < cellCount - 4; i++) begin
            keysCurrentState = randomKeys(1'b1);
            driveRandomEntry();
            stepCycle();
        end
        keysCurrentState = '0;
        repeat (12) begin
            driveRandomEntry();
            stepCycle();
        end
        checkValue(32'(currentView), 32'(viewIram), "view after second sweep");

        $display("Test passed");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+include
source/panelPkg.sv
source/viewSelector.sv
source/keyEntry.sv
source/displayWriter.sv
source/displayPanel.sv
tests/displayPanel_props.sv
tests/displayPanelTb.sv
